//--- build.f
clint_bus_pkg.sv
clint_timer_pkg.sv
clint_bus_stage.sv
clint_tick_gen.sv
clint_regs.sv
clint_irq.sv
clint_top.sv
clint_props.sv
clint_tb.sv

//--- Bender.yml
package:
  name: clint

sources:
  - clint_bus_pkg.sv
  - clint_timer_pkg.sv
  - clint_bus_stage.sv
  - clint_tick_gen.sv
  - clint_regs.sv
  - clint_irq.sv
  - clint_top.sv
  - target: simulation
    files:
      - clint_props.sv
      - clint_tb.sv

//--- clint_tb.sv
`default_nettype none

module clint_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic clock;
  logic reset;
  logic rd_en;
  logic wr_en;
  logic [2:0] addr;
  logic [31:0] wr_data;
  logic [31:0] rd_data;
  logic busy;
  clint_timer_pkg::clint_irq_t irq;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [31:0] lfsr;
  int errors;
  int errors_at_start;
  int tests_failed;
  int assert_fails;

  clint_top #(.XLEN(32), .TICK_DIV(4)) dut (
    .clock(clock), .reset(reset), .rd_en(rd_en), .wr_en(wr_en), .addr(addr),
    .wr_data(wr_data), .rd_data(rd_data), .busy(busy), .irq(irq),
    .mtime(mtime), .mtimecmp(mtimecmp)
  );

  always #10 clock = ~clock;

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] next_random();
    logic [31:0] word;
    int i;
    word = '0;
    for (i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      word = {word[30:0], lfsr[0]};
    end
    return word;
  endfunction

  task automatic step();
    @(posedge clock);
    #2;
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      $display("test %s done, no errors", name);
    end else begin
      tests_failed++;
      $display("test %s done, %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  task automatic bus_write(input logic [2:0] a, input logic [31:0] data);
    addr = a;
    wr_data = data;
    wr_en = 1'b1;
    step();
    wr_en = 1'b0;
  endtask

  // Read data is combinational and sampled mid-cycle
  task automatic bus_read(input logic [2:0] a, output logic [31:0] data);
    addr = a;
    rd_en = 1'b1;
    @(negedge clock);
    data = rd_data;
    step();
    rd_en = 1'b0;
  endtask

  task automatic read_reset_state();
    logic [2:0] zero_addrs [5] = '{3'd0, 3'd1, 3'd3, 3'd7, 3'd6};
    logic [31:0] data;
    int i;
    check_value("busy", 0, busy);
    check_value("irq", 0, irq);
    step();
    // Only mtip, since mtime equals mtimecmp at zero
    check_value("irq", 3'b001, irq);
    for (i = 0; i < 5; i++) begin
      bus_read(zero_addrs[i], data);
      check_value($sformatf("rd_data@%0d", zero_addrs[i]), 0, data);
    end
    // Six cycles since reset allow at most two ticks
    bus_read(3'd2, data);
    assert (data <= 32'd2) else begin
      $display("FAILED t=%0t mtime lo expected at most 2 actual %h", $time, data);
      errors++;
    end
    finish_test("reset_state");
  endtask

  task automatic drive_soft_irq();
    logic [31:0] value;
    logic [31:0] data;
    int i;
    for (i = 0; i < 4; i++) begin
      value = next_random();
      bus_write(i[2:0] & 3'd1, value);
      step();
      check_value((i % 2 == 0) ? "irq.msip" : "irq.ssip", value[0],
                  (i % 2 == 0) ? irq.msip : irq.ssip);
      bus_read(i[2:0] & 3'd1, data);
      check_value((i % 2 == 0) ? "msip" : "ssip", value, data);
    end
    finish_test("soft_irq");
  endtask

  task automatic access_halves();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] data;
    lo = next_random();
    hi = next_random();
    bus_write(3'd3, lo);
    bus_read(3'd3, data);
    check_value("mtimecmp lo", lo, data);
    bus_read(3'd7, data);
    check_value("mtimecmp hi", 0, data);
    bus_write(3'd7, hi);
    bus_read(3'd7, data);
    check_value("mtimecmp hi", hi, data);
    bus_read(3'd3, data);
    check_value("mtimecmp lo", lo, data);
    check_value("mtimecmp", {hi, lo}, mtimecmp);
    finish_test("half_access");
  endtask

  task automatic count_ticks();
    logic [63:0] prev;
    int i;
    bus_write(3'd6, 32'd0);
    bus_write(3'd2, 32'h0000_0100);
    check_value("mtime", 64'h100, mtime);
    prev = mtime;
    for (i = 0; i < 40; i++) begin
      step();
      assert (mtime >= prev) else begin
        $display("FAILED t=%0t mtime expected >= %h actual %h", $time, prev, mtime);
        errors++;
      end
      prev = mtime;
    end
    assert (prev - 64'h100 >= 9 && prev - 64'h100 <= 10) else begin
      $display("FAILED t=%0t mtime increase expected 9..10 actual %0d", $time,
               prev - 64'h100);
      errors++;
    end
    finish_test("counting");
  endtask

  task automatic raise_timer_irq();
    logic [63:0] target;
    int waited;
    target = mtime + 64'd6;
    bus_write(3'd7, target[63:32]);
    bus_write(3'd3, target[31:0]);
    check_value("mtimecmp", target, mtimecmp);
    step();
    check_value("irq.mtip", 0, irq.mtip);
    waited = 0;
    while (!irq.mtip && waited < 200) begin
      step();
      waited++;
    end
    if (!irq.mtip) begin
      $display("Timeout: irq.mtip did not rise within 200 cycles");
      errors++;
    end else begin
      assert (mtime >= mtimecmp) else begin
        $display("FAILED t=%0t mtime expected >= %h actual %h", $time, mtimecmp, mtime);
        errors++;
      end
    end
    finish_test("timer_irq");
  endtask

  task automatic pulse_busy();
    int i;
    int waited;
    waited = 0;
    while (busy && waited < 10) begin
      step();
      waited++;
    end
    assert (!busy) else begin
      $display("Timeout: busy did not drop before the pulse test");
      errors++;
    end
    addr = 3'd0;
    rd_en = 1'b1;
    step();
    rd_en = 1'b0;
    check_value("busy", 1, busy);
    step();
    check_value("busy", 0, busy);
    // Held strobe makes busy toggle
    addr = 3'd1;
    wr_data = '0;
    wr_en = 1'b1;
    for (i = 0; i < 4; i++) begin
      step();
      check_value("busy", (i % 2 == 0) ? 1 : 0, busy);
    end
    wr_en = 1'b0;
    finish_test("busy_pulse");
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    rd_en = 1'b0;
    wr_en = 1'b0;
    addr = '0;
    wr_data = '0;
    lfsr = 32'h1c00;
    errors = 0;
    errors_at_start = 0;
    tests_failed = 0;
    assert_fails = 0;
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b0;
    read_reset_state();
    drive_soft_irq();
    access_halves();
    count_ticks();
    raise_timer_irq();
    pulse_busy();
    assert_fails = dut.u_props.fail_count;
    $display("6 tests run, %0d failed, %0d errors, %0d assertion failures",
             tests_failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- clint_props.sv
`default_nettype none

module clint_props (
  input wire logic                        clock,
  input wire logic                        reset,
  input wire logic                        rd_en,
  input wire logic                        wr_en,
  input wire logic                        busy,
  input wire clint_timer_pkg::clint_irq_t irq
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // Busy is a single-cycle pulse
  busy_one_cycle: assert property (@(posedge clock) disable iff (reset)
    (busy && !rd_en && !wr_en) |=> !busy)
    else begin
      fail_count++;
      $error("busy stayed high for two cycles with no strobe");
    end

  busy_after_access: assert property (@(posedge clock) disable iff (reset)
    ((rd_en || wr_en) && !busy) |=> busy)
    else begin
      fail_count++;
      $error("access with busy low was not followed by busy");
    end

  irq_clear_after_reset: assert property (@(posedge clock) $fell(reset) |-> (irq == '0))
    else begin
      fail_count++;
      $error("irq not zero in the first cycle after reset");
    end

endmodule

bind clint_top clint_props u_props (
  .clock(clock),
  .reset(reset),
  .rd_en(rd_en),
  .wr_en(wr_en),
  .busy (busy),
  .irq  (irq)
);

`default_nettype wire

//--- clint_top.sv
`default_nettype none

module clint_top #(
  parameter int XLEN     = 32,
  parameter int TICK_DIV = 4
) (
  input  wire logic                              clock,
  input  wire logic                              reset,
  input  wire logic                              rd_en,
  input  wire logic                              wr_en,
  input  wire logic [clint_bus_pkg::ADDR_W-1:0]  addr,
  input  wire logic [XLEN-1:0]                   wr_data,
  output logic [XLEN-1:0]                        rd_data,
  output logic                                   busy,
  output clint_timer_pkg::clint_irq_t            irq,
  output logic [63:0]                            mtime,
  output logic [63:0]                            mtimecmp
);

  clint_bus_pkg::clint_access_t access;
  clint_timer_pkg::timer_word_u mtime_w;
  clint_timer_pkg::timer_word_u mtimecmp_w;
  logic tick;
  logic msip_bit;
  logic ssip_bit;

  clint_bus_stage #(
    .XLEN(XLEN)
  ) u_bus_stage (
    .clock (clock),
    .reset (reset),
    .rd_en (rd_en),
    .wr_en (wr_en),
    .addr  (addr),
    .access(access),
    .busy  (busy)
  );

  clint_tick_gen #(
    .TICK_DIV(TICK_DIV)
  ) u_tick_gen (
    .clock(clock),
    .reset(reset),
    .tick (tick)
  );

  clint_regs #(
    .XLEN(XLEN)
  ) u_regs (
    .clock   (clock),
    .reset   (reset),
    .access  (access),
    .wr_data (wr_data),
    .tick    (tick),
    .rd_data (rd_data),
    .msip_bit(msip_bit),
    .ssip_bit(ssip_bit),
    .mtime   (mtime_w),
    .mtimecmp(mtimecmp_w)
  );

  clint_irq u_irq (
    .clock   (clock),
    .reset   (reset),
    .msip_bit(msip_bit),
    .ssip_bit(ssip_bit),
    .mtime   (mtime_w),
    .mtimecmp(mtimecmp_w),
    .irq     (irq)
  );

  // Timer values for the core's time CSR
  assign mtime    = mtime_w.whole;
  assign mtimecmp = mtimecmp_w.whole;

endmodule

`default_nettype wire

//--- clint_irq.sv
`default_nettype none

module clint_irq (
  input  wire logic                          clock,
  input  wire logic                          reset,
  input  wire logic                          msip_bit,
  input  wire logic                          ssip_bit,
  input  wire clint_timer_pkg::timer_word_u  mtime,
  input  wire clint_timer_pkg::timer_word_u  mtimecmp,
  output clint_timer_pkg::clint_irq_t        irq
);

  logic mtip_next;

  // Unsigned compare on the full timer words
  assign mtip_next = (mtime.whole >= mtimecmp.whole);

  // Registered so the core sees clean levels
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      irq <= '0;
    end else begin
      irq.msip <= msip_bit;
      irq.ssip <= ssip_bit;
      irq.mtip <= mtip_next;
    end
  end

endmodule

`default_nettype wire

//--- clint_regs.sv
`default_nettype none

module clint_regs #(
  parameter int XLEN = 32
) (
  input  wire logic                          clock,
  input  wire logic                          reset,
  input  wire clint_bus_pkg::clint_access_t  access,
  input  wire logic [XLEN-1:0]               wr_data,
  input  wire logic                          tick,
  output logic [XLEN-1:0]                    rd_data,
  output logic                               msip_bit,
  output logic                               ssip_bit,
  output clint_timer_pkg::timer_word_u       mtime,
  output clint_timer_pkg::timer_word_u       mtimecmp
);

  logic [XLEN-1:0] msip_q;
  logic [XLEN-1:0] ssip_q;
  clint_timer_pkg::timer_word_u mtime_q;
  clint_timer_pkg::timer_word_u mtimecmp_q;

  // Next timer values on a write, and timer read words
  clint_timer_pkg::timer_word_u mtime_wval;
  clint_timer_pkg::timer_word_u mtimecmp_wval;
  logic [XLEN-1:0] mtime_rval;
  logic [XLEN-1:0] mtimecmp_rval;

  logic wr_msip;
  logic wr_ssip;
  logic wr_mtime;
  logic wr_mtimecmp;

  assign wr_msip     = access.wr && (access.sel == clint_bus_pkg::SEL_MSIP);
  assign wr_ssip     = access.wr && (access.sel == clint_bus_pkg::SEL_SSIP);
  assign wr_mtime    = access.wr && (access.sel == clint_bus_pkg::SEL_MTIME);
  assign wr_mtimecmp = access.wr && (access.sel == clint_bus_pkg::SEL_MTIMECMP);

  if (XLEN == 64) begin : g_xlen64
    always_comb begin
      mtime_wval.whole    = wr_data;
      mtimecmp_wval.whole = wr_data;
      mtime_rval          = mtime_q.whole;
      mtimecmp_rval       = mtimecmp_q.whole;
    end
  end else begin : g_xlen32
    // Only the addressed half changes, the other keeps its value
    always_comb begin
      mtime_wval    = mtime_q;
      mtimecmp_wval = mtimecmp_q;
      if (access.hi_half) begin
        mtime_wval.halves.hi    = wr_data;
        mtimecmp_wval.halves.hi = wr_data;
        mtime_rval              = mtime_q.halves.hi;
        mtimecmp_rval           = mtimecmp_q.halves.hi;
      end else begin
        mtime_wval.halves.lo    = wr_data;
        mtimecmp_wval.halves.lo = wr_data;
        mtime_rval              = mtime_q.halves.lo;
        mtimecmp_rval           = mtimecmp_q.halves.lo;
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      msip_q     <= '0;
      ssip_q     <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '0;
    end else begin
      if (wr_msip) begin
        msip_q <= wr_data;
      end
      if (wr_ssip) begin
        ssip_q <= wr_data;
      end
      // Write wins over a tick in the same cycle
      if (wr_mtime) begin
        mtime_q <= mtime_wval;
      end else if (tick) begin
        mtime_q.whole <= mtime_q.whole + 64'd1;
      end
      if (wr_mtimecmp) begin
        mtimecmp_q <= mtimecmp_wval;
      end
    end
  end

  // Read data follows the address, the read strobe is not needed
  always_comb begin
    case (access.sel)
      clint_bus_pkg::SEL_MSIP:  rd_data = msip_q;
      clint_bus_pkg::SEL_SSIP:  rd_data = ssip_q;
      clint_bus_pkg::SEL_MTIME: rd_data = mtime_rval;
      default:                  rd_data = mtimecmp_rval;
    endcase
  end

  assign msip_bit = msip_q[0];
  assign ssip_bit = ssip_q[0];
  assign mtime    = mtime_q;
  assign mtimecmp = mtimecmp_q;

endmodule

`default_nettype wire

//--- clint_tick_gen.sv
`default_nettype none

module clint_tick_gen #(
  parameter int TICK_DIV = 4
) (
  input  wire logic clock,
  input  wire logic reset,
  output logic      tick
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_DIV - 1);

  logic [CNT_W-1:0] count;

  // Down-counter, reloads when it hits zero
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      count <= RELOAD;
    end else if (count == '0) begin
      count <= RELOAD;
    end else begin
      count <= count - CNT_W'(1);
    end
  end

  // With TICK_DIV of 1 the count stays at zero
  assign tick = (count == '0);

endmodule

`default_nettype wire

//--- clint_bus_stage.sv
`default_nettype none

module clint_bus_stage #(
  parameter int XLEN = 32
) (
  input  wire logic                              clock,
  input  wire logic                              reset,
  input  wire logic                              rd_en,
  input  wire logic                              wr_en,
  input  wire logic [clint_bus_pkg::ADDR_W-1:0]  addr,
  output clint_bus_pkg::clint_access_t           access,
  output logic                                   busy
);

  logic any_access;

  always_comb begin
    access.sel = clint_bus_pkg::clint_sel_e'(addr[1:0]);
    // A 64-bit bus reaches the timer words whole
    if (XLEN == 32) begin
      access.hi_half = addr[clint_bus_pkg::HALF_BIT];
    end else begin
      access.hi_half = 1'b0;
    end
    access.wr = wr_en;
    access.rd = rd_en;
  end

  assign any_access = access.rd | access.wr;

  // Busy is high for one cycle after an access, then drops again
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (busy) begin
      busy <= 1'b0;
    end else if (any_access) begin
      busy <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- clint_timer_pkg.sv
`default_nettype none

package clint_timer_pkg;

  // Upper and lower words of a 64-bit timer register
  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } timer_halves_t;

  // Same timer word, seen whole or as two halves
  typedef union packed {
    logic [63:0]   whole;
    timer_halves_t halves;
  } timer_word_u;

  // Pending levels towards the core
  typedef struct packed {
    logic msip;
    logic ssip;
    logic mtip;
  } clint_irq_t;

endpackage

`default_nettype wire

//--- clint_bus_pkg.sv
`default_nettype none

package clint_bus_pkg;

  // Bus address width, byte offsets are not decoded
  localparam int ADDR_W = 3;

  // Address bit choosing the upper timer half on a 32-bit bus
  localparam int HALF_BIT = 2;

  // Register map on address bits 1:0
  typedef enum logic [1:0] {
    SEL_MSIP     = 2'b00,
    SEL_SSIP     = 2'b01,
    SEL_MTIME    = 2'b10,
    SEL_MTIMECMP = 2'b11
  } clint_sel_e;

  // One decoded bus access
  typedef struct packed {
    clint_sel_e sel;
    logic       hi_half;
    logic       wr;
    logic       rd;
  } clint_access_t;

endpackage

`default_nettype wire
